/* Makefile */
VERILATOR = verilator
TOP       = core_tb
FILELIST  = list.f
FLAGS     = --binary --timing --assert -j 0
LOG       = sim.log
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/core_sva.sv */
`timescale 1ns/1ns

module core_sva import core_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      redirect_valid,
    input logic      ds_valid,
    input logic      ds_hold,
    input ds_to_es_t ds_to_es,
    input logic      es_valid,
    input logic      ms_hit_rj,
    input logic      ms_hit_rk,
    input es_to_ms_t es_to_ms
);

    a_no_redirect_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !redirect_valid)
        else $error("redirect raised during reset");

    // held decode word comes back unchanged
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        ds_valid && ds_hold |=> ds_valid && $stable(ds_to_es.pc) && $stable(ds_to_es.dest))
        else $error("held instruction changed");

    a_no_load_forward: assert property (@(posedge clk) disable iff (reset)
        es_valid && (ms_hit_rj || ms_hit_rk) |-> !es_to_ms.is_load)
        else $error("forwarded from a load in memory");

endmodule

bind exe_stage core_sva u_sva (
    .clk            (clk),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .ds_valid       (ds_valid),
    .ds_hold        (ds_hold),
    .ds_to_es       (ds_to_es),
    .es_valid       (es_valid),
    .ms_hit_rj      (ms_hit_rj),
    .ms_hit_rk      (ms_hit_rk),
    .es_to_ms       (es_to_ms)
);

/* bench/core_tb.sv */
`timescale 1ns/1ns

module core_tb import core_pkg::*; ();

    localparam int PROG_LEN = 200;
    localparam logic [31:0] END_PC = PROG_LEN * 4;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_valid;
    logic        inst_ready;
    inst_u       inst;
    logic [31:0] inst_pc;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] mreg [32];          // model registers
    logic [31:0] mmem [DMEM_WORDS];
    logic [31:0] rng = 32'h1daddd58;
    logic [31:0] fpc;                // fetch pc
    logic [31:0] mpc;                // model pc
    logic [31:0] redir_q [$];
    logic        xfer;
    logic        run;
    int          cycles;

    core_top UUT (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int pick(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic logic [31:0] enc_i(input op_e op, input int rd, input int rj,
                                          input logic [15:0] imm);
        return {op, 5'(rd), 5'(rj), imm};
    endfunction

    task automatic build_program();
        op_e rr_ops [9];
        int  kind;
        int  off;
        rr_ops = '{ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL};
        for (int r = 1; r < 8; r++)
            prog[r-1] = enc_i(ADDI, r, 0, 16'(next_rand() >> 8));
        for (int k = 0; k < 8; k++)
            prog[7+k] = enc_i(ST, k, 0, 16'(k));   // fill data words 0..7
        for (int i = 15; i < PROG_LEN; i++) begin
            kind = pick(16);
            off  = 2 + pick(3);
            if (i + off > PROG_LEN)
                off = PROG_LEN - i;
            if (kind < 9)
                prog[i] = {rr_ops[kind], 5'(pick(8)), 5'(pick(8)), 5'(pick(8)), 11'd0};
            else if (kind == 9 || ((kind == 14 || kind == 15) && off < 2))
                prog[i] = enc_i(ADDI, pick(8), pick(8), 16'(next_rand() >> 8));
            else if (kind == 10)
                prog[i] = enc_i(ANDI, pick(8), pick(8), 16'(next_rand() >> 8));
            else if (kind == 11)
                prog[i] = enc_i(ORI, pick(8), pick(8), 16'(next_rand() >> 8));
            else if (kind == 12)
                prog[i] = enc_i(LD, pick(8), 0, 16'(pick(8)));
            else if (kind == 13)
                prog[i] = enc_i(ST, pick(8), 0, 16'(pick(8)));
            else if (kind == 14)
                prog[i] = enc_i(pick(2) == 0 ? BEQ : BNE, pick(8), pick(8), 16'(off));
            else
                prog[i] = enc_i(JAL, pick(8), 0, 16'(off));
        end
    endtask

    // ISA interpreter stepping one instruction per call
    function automatic retire_t ref_step(input logic [31:0] pc, output logic [31:0] npc);
        logic [31:0] w;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] imm;
        logic [31:0] val;
        logic        wr;
        retire_t     rr;
        w   = prog[pc >> 2];
        rd  = w[25:21];
        a   = mreg[w[20:16]];
        b   = mreg[w[15:11]];
        c   = mreg[rd];
        imm = {{16{w[15]}}, w[15:0]};
        npc = pc + 4;
        wr  = 1'b1;
        val = 32'd0;
        case (op_e'(w[31:26]))
            ADD:  val = a + b;
            SUB:  val = a - b;
            AND:  val = a & b;
            OR:   val = a | b;
            XOR:  val = a ^ b;
            SLT:  val = {31'd0, $signed(a) < $signed(b)};
            SLTU: val = {31'd0, a < b};
            SLL:  val = a << b[4:0];
            SRL:  val = a >> b[4:0];
            ADDI: val = a + imm;
            ANDI: val = a & imm;
            ORI:  val = a | imm;
            LD:   val = mmem[8'(a + imm)];
            ST: begin
                mmem[8'(a + imm)] = c;
                wr = 1'b0;
            end
            BEQ: begin
                wr = 1'b0;
                if (a == c)
                    npc = pc + (imm << 2);
            end
            BNE: begin
                wr = 1'b0;
                if (a != c)
                    npc = pc + (imm << 2);
            end
            JAL: begin
                val = pc + 4;
                npc = pc + (imm << 2);
            end
            default: wr = 1'b0;
        endcase
        rr.pc     = pc;
        rr.reg_we = wr && rd != 5'd0;
        rr.dest   = rr.reg_we ? rd : 5'd0;
        rr.value  = val;
        if (rr.reg_we)
            mreg[rd] = val;
        return rr;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        abort($sformatf("[ERROR] %0t ns: %s", $time, msg));
    endtask

    task automatic compare_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc || got.reg_we !== exp.reg_we || got.dest !== exp.dest)
            value_error($sformatf("retire pc %h we %b rd %0d, expected pc %h we %b rd %0d",
                got.pc, got.reg_we, got.dest, exp.pc, exp.reg_we, exp.dest));
        else if (exp.reg_we && got.value !== exp.value)
            value_error($sformatf("pc %h r%0d = %h, expected %h",
                got.pc, got.dest, got.value, exp.value));
    endtask

    task automatic compare_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            value_error($sformatf("redirect_pc %h, expected %h", got, exp));
    endtask

    always @(posedge clk)
        xfer <= inst_valid && inst_ready;

    // fetch model
    always @(negedge clk) begin
        if (run) begin
            if (redirect_valid)
                fpc = redirect_pc;
            else if (xfer)
                fpc = fpc + 4;
            if (redirect_valid || xfer || !inst_valid) begin
                if (fpc >= END_PC || pick(4) == 0) begin
                    inst_valid = 1'b0;   // gap
                end else begin
                    inst_valid = 1'b1;
                    inst       = prog[fpc >> 2];
                    inst_pc    = fpc;
                end
            end
        end
    end

    // compare process
    always @(negedge clk) begin
        retire_t     exp;
        logic [31:0] npc;
        if (run) begin
            if (redirect_valid)
                redir_q.push_back(redirect_pc);
            if (retire_valid) begin
                if (mpc >= END_PC)
                    abort("an instruction retired after the end of the program");
                exp = ref_step(mpc, npc);
                compare_retire(retire, exp);
                if (npc != mpc + 4) begin
                    if (redir_q.size() == 0)
                        abort($sformatf("taken branch at pc %h gave no redirect", mpc));
                    compare_pc(redir_q.pop_front(), npc);
                end
                mpc = npc;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = 32'd0;
        run        = 1'b0;
        fpc        = 32'd0;
        mpc        = 32'd0;
        for (int i = 0; i < 32; i++)
            mreg[i] = 32'd0;
        for (int i = 0; i < DMEM_WORDS; i++)
            mmem[i] = 32'd0;
        build_program();
        repeat (5) @(negedge clk);
        if (inst_ready !== 1'b0 || redirect_valid !== 1'b0 || retire_valid !== 1'b0)
            value_error("ready, redirect or retire not low in reset");
        reset = 1'b0;
        run   = 1'b1;
        cycles = 0;
        while (mpc < END_PC) begin
            @(negedge clk);
            cycles++;
            if (cycles > 5000)
                abort("timeout: the program never reached its end");
        end
        cycles = 0;
        while (cycles < 8) begin   // let any stray retire show up
            @(negedge clk);
            cycles++;
        end
        if (redir_q.size() != 0) begin
            abort("a redirect was seen with no taken branch behind it");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    typedef enum logic [5:0] {
        ADD  = 6'h01,
        SUB  = 6'h02,
        AND  = 6'h03,
        OR   = 6'h04,
        XOR  = 6'h05,
        SLT  = 6'h06,
        SLTU = 6'h07,
        SLL  = 6'h08,
        SRL  = 6'h09,
        ADDI = 6'h10,
        ANDI = 6'h11,
        ORI  = 6'h12,
        LD   = 6'h18,
        ST   = 6'h19,
        BEQ  = 6'h20,
        BNE  = 6'h21,
        JAL  = 6'h22
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JAL} br_e;

    // one word, two field layouts
    typedef union packed {
        struct packed {
            op_e         op;
            logic [4:0]  rd;
            logic [4:0]  rj;
            logic [4:0]  rk;
            logic [10:0] unused;
        } r;
        struct packed {
            op_e         op;
            logic [4:0]  rd;    // second source for st/beq/bne
            logic [4:0]  rj;
            logic [15:0] imm;
        } i;
    } inst_u;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic        src2_is_imm;
        logic        src1_is_pc;
        logic        src2_is_4;
        logic        is_load;
        logic        is_store;
        br_e         br;
        logic        reg_we;
        logic [4:0]  dest;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] rj_value;
        logic [31:0] rk_value;
        logic [31:0] imm;
    } ds_to_es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        reg_we;
        logic [4:0]  dest;
        logic        is_load;
        logic [31:0] result;  // word address for ld
    } es_to_ms_t;

    typedef struct packed {
        logic        reg_we;
        logic [4:0]  dest;
        logic [31:0] value;
    } fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        reg_we;
        logic [4:0]  dest;
        logic [31:0] value;
    } retire_t;

endpackage

/* hdl/core_top.sv */
`timescale 1ns/1ns

module core_top import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    output logic        inst_ready,
    input  inst_u       inst,
    input  logic [31:0] inst_pc,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        retire_valid,
    output retire_t     retire
);

    ds_to_es_t          ds_to_es;
    logic               ds_valid;
    logic               ds_hold;
    logic [4:0]         es_dest;
    logic               es_is_load;
    logic               es_valid;
    es_to_ms_t          es_to_ms;
    logic               ms_valid;
    fwd_t               ms_fwd;
    fwd_t               wb_fwd;
    logic               dmem_we;
    logic [DMEM_AW-1:0] dmem_addr;
    logic [31:0]        dmem_wdata;

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .squash     (redirect_valid),
        .es_dest    (es_dest),
        .es_is_load (es_is_load),
        .es_valid   (es_valid),
        .wb_we      (wb_fwd.reg_we),
        .wb_dest    (wb_fwd.dest),
        .wb_value   (wb_fwd.value),
        .ds_to_es   (ds_to_es),
        .ds_valid   (ds_valid),
        .ds_hold    (ds_hold)
    );

    exe_stage u_exe (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es       (ds_to_es),
        .ds_valid       (ds_valid),
        .ds_hold        (ds_hold),
        .ms_fwd         (ms_fwd),
        .wb_fwd         (wb_fwd),
        .es_to_ms       (es_to_ms),
        .ms_valid       (ms_valid),
        .es_dest        (es_dest),
        .es_is_load     (es_is_load),
        .es_valid       (es_valid),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dmem_we        (dmem_we),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata)
    );

    mem_stage u_mem (
        .clk          (clk),
        .reset        (reset),
        .es_to_ms     (es_to_ms),
        .ms_valid     (ms_valid),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .ms_fwd       (ms_fwd),
        .wb_fwd       (wb_fwd),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    output logic        inst_ready,
    input  inst_u       inst,
    input  logic [31:0] inst_pc,
    input  logic        squash,
    input  logic [4:0]  es_dest,
    input  logic        es_is_load,
    input  logic        es_valid,
    input  logic        wb_we,
    input  logic [4:0]  wb_dest,
    input  logic [31:0] wb_value,
    output ds_to_es_t   ds_to_es,
    output logic        ds_valid,
    output logic        ds_hold
);

    inst_u       ir;
    logic [31:0] ir_pc;
    logic        live;
    logic        accept;
    logic        wr;
    ds_to_es_t   dec;       // decode without register values
    logic [31:0] rj_value;
    logic [31:0] rk_value;

    function automatic alu_op_e rr_alu(input op_e op);
        case (op)
            SUB:     return ALU_SUB;
            AND:     return ALU_AND;
            OR:      return ALU_OR;
            XOR:     return ALU_XOR;
            SLT:     return ALU_SLT;
            SLTU:    return ALU_SLTU;
            SLL:     return ALU_SLL;
            SRL:     return ALU_SRL;
            default: return ALU_ADD;
        endcase
    endfunction

    assign inst_ready = live && !ds_hold && !squash;
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            live     <= 1'b0;
            ds_valid <= 1'b0;
        end else begin
            live <= 1'b1;
            if (squash)
                ds_valid <= 1'b0;   // younger than a taken branch
            else if (!ds_hold)
                ds_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ir    <= inst;
            ir_pc <= inst_pc;
        end
    end

    always_comb begin
        dec        = '0;
        dec.pc     = ir_pc;
        dec.imm    = {{16{ir.i.imm[15]}}, ir.i.imm};
        dec.alu_op = ALU_PASS;
        dec.br     = BR_NONE;
        dec.rj     = ir.i.rj;
        wr         = 1'b0;
        case (ir.r.op)
            ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL: begin
                dec.alu_op = rr_alu(ir.r.op);
                dec.rk     = ir.r.rk;
                wr         = 1'b1;
            end
            ADDI, ANDI, ORI, LD: begin
                dec.alu_op      = ir.i.op == ANDI ? ALU_AND :
                                  ir.i.op == ORI  ? ALU_OR  : ALU_ADD;
                dec.src2_is_imm = 1'b1;
                dec.is_load     = ir.i.op == LD;
                wr              = 1'b1;
            end
            ST: begin
                dec.alu_op      = ALU_ADD;
                dec.src2_is_imm = 1'b1;
                dec.is_store    = 1'b1;
                dec.rk          = ir.i.rd;
            end
            BEQ, BNE: begin
                dec.br = ir.i.op == BEQ ? BR_EQ : BR_NE;
                dec.rk = ir.i.rd;
            end
            JAL: begin
                dec.alu_op     = ALU_ADD;  // link value pc + 4
                dec.src1_is_pc = 1'b1;
                dec.src2_is_4  = 1'b1;
                dec.br         = BR_JAL;
                dec.rj         = 5'd0;
                wr             = 1'b1;
            end
            default: dec.rj = 5'd0;   // unknown opcode runs as a nop
        endcase
        dec.reg_we = wr && ir.i.rd != 5'd0;
        dec.dest   = dec.reg_we ? ir.i.rd : 5'd0;
    end

    always_comb begin
        ds_to_es          = dec;
        ds_to_es.rj_value = rj_value;
        ds_to_es.rk_value = rk_value;
    end

    // load result only exists after the memory stage
    assign ds_hold = ds_valid && es_valid && es_is_load && es_dest != 5'd0 &&
                     (es_dest == dec.rj || es_dest == dec.rk);

    reg_file u_reg_file (
        .clk      (clk),
        .rj       (dec.rj),
        .rk       (dec.rk),
        .rj_value (rj_value),
        .rk_value (rk_value),
        .we       (wb_we),
        .waddr    (wb_dest),
        .wdata    (wb_value)
    );

endmodule

/* hdl/exe_stage.sv */
`timescale 1ns/1ns

module exe_stage import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  ds_to_es_t          ds_to_es,
    input  logic               ds_valid,
    input  logic               ds_hold,
    input  fwd_t               ms_fwd,
    input  fwd_t               wb_fwd,
    output es_to_ms_t          es_to_ms,
    output logic               ms_valid,
    output logic [4:0]         es_dest,
    output logic               es_is_load,
    output logic               es_valid,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc,
    output logic               dmem_we,
    output logic [DMEM_AW-1:0] dmem_addr,
    output logic [31:0]        dmem_wdata
);

    ds_to_es_t   es_r;
    logic        ms_hit_rj;
    logic        ms_hit_rk;
    logic        wb_hit_rj;
    logic        wb_hit_rk;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        br_taken;
    logic [31:0] br_target;

    // bubble on a load-use hold or behind our own redirect
    always_ff @(posedge clk) begin
        if (reset)
            es_valid <= 1'b0;
        else
            es_valid <= ds_valid && !ds_hold && !redirect_valid;
    end

    always_ff @(posedge clk) begin
        es_r <= ds_to_es;
    end

    assign es_dest    = es_r.dest;
    assign es_is_load = es_r.is_load;

    // memory stage wins over writeback
    assign ms_hit_rj = ms_fwd.reg_we && es_r.rj != 5'd0 && ms_fwd.dest == es_r.rj;
    assign ms_hit_rk = ms_fwd.reg_we && es_r.rk != 5'd0 && ms_fwd.dest == es_r.rk;
    assign wb_hit_rj = wb_fwd.reg_we && es_r.rj != 5'd0 && wb_fwd.dest == es_r.rj;
    assign wb_hit_rk = wb_fwd.reg_we && es_r.rk != 5'd0 && wb_fwd.dest == es_r.rk;

    assign src1 = ms_hit_rj ? ms_fwd.value :
                  wb_hit_rj ? wb_fwd.value : es_r.rj_value;
    assign src2 = ms_hit_rk ? ms_fwd.value :
                  wb_hit_rk ? wb_fwd.value : es_r.rk_value;

    assign alu_a = es_r.src1_is_pc ? es_r.pc : src1;
    assign alu_b = es_r.src2_is_4   ? 32'd4    :
                   es_r.src2_is_imm ? es_r.imm : src2;

    always_comb begin
        case (es_r.alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SLT:  alu_result = {31'd0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'd0, alu_a < alu_b};
            ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            default:  alu_result = alu_b;
        endcase
    end

    always_comb begin
        case (es_r.br)
            BR_EQ:   br_taken = src1 == src2;
            BR_NE:   br_taken = src1 != src2;
            BR_JAL:  br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target      = es_r.pc + {es_r.imm[29:0], 2'b00};  // word offset
    assign redirect_valid = es_valid && br_taken;
    assign redirect_pc    = br_target;

    assign dmem_we    = es_valid && es_r.is_store;
    assign dmem_addr  = alu_result[DMEM_AW-1:0];
    assign dmem_wdata = src2;

    always_ff @(posedge clk) begin
        if (reset)
            ms_valid <= 1'b0;
        else
            ms_valid <= es_valid;
    end

    always_ff @(posedge clk) begin
        es_to_ms.pc      <= es_r.pc;
        es_to_ms.reg_we  <= es_r.reg_we;
        es_to_ms.dest    <= es_r.dest;
        es_to_ms.is_load <= es_r.is_load;
        es_to_ms.result  <= alu_result;
    end

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage import core_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  es_to_ms_t          es_to_ms,
    input  logic               ms_valid,
    input  logic               dmem_we,
    input  logic [DMEM_AW-1:0] dmem_addr,
    input  logic [31:0]        dmem_wdata,
    output fwd_t               ms_fwd,
    output fwd_t               wb_fwd,
    output logic               retire_valid,
    output retire_t            retire
);

    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] load_data;
    es_to_ms_t   wb_r;
    logic        wb_valid;
    logic [31:0] wb_value;

    // store from execute, load read at the end of the memory cycle
    always_ff @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_addr] <= dmem_wdata;
        load_data <= dmem[es_to_ms.result[DMEM_AW-1:0]];
    end

    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= ms_valid;
    end

    always_ff @(posedge clk) begin
        wb_r <= es_to_ms;
    end

    assign wb_value = wb_r.is_load ? load_data : wb_r.result;

    // a load here still carries its address, decode keeps users away
    assign ms_fwd = '{
        reg_we: ms_valid && es_to_ms.reg_we,
        dest:   es_to_ms.dest,
        value:  es_to_ms.result
    };

    assign wb_fwd = '{
        reg_we: wb_valid && wb_r.reg_we,
        dest:   wb_r.dest,
        value:  wb_value
    };

    assign retire_valid = wb_valid;
    assign retire = '{
        pc:     wb_r.pc,
        reg_we: wb_r.reg_we,
        dest:   wb_r.dest,
        value:  wb_value
    };

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic        clk,
    input  logic [4:0]  rj,
    input  logic [4:0]  rk,
    output logic [31:0] rj_value,
    output logic [31:0] rk_value,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0)
            regs[waddr] <= wdata;
    end

    // write-through so decode sees the writeback value this cycle
    always_comb begin
        if (rj == 5'd0)
            rj_value = 32'd0;
        else if (we && waddr == rj)
            rj_value = wdata;
        else
            rj_value = regs[rj];

        if (rk == 5'd0)
            rk_value = 32'd0;
        else if (we && waddr == rk)
            rk_value = wdata;
        else
            rk_value = regs[rk];
    end

endmodule

/* list.f */
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/exe_stage.sv
hdl/mem_stage.sv
hdl/core_top.sv
bench/core_sva.sv
bench/core_tb.sv
